/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = fftAccelTb
RTLTOP    = fftAccel
FILELIST  = verilog.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTLTOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* verif/fftAccelTb.sv */
`timescale 1ns/1ps

module fftAccelTb;

    import fftPkg::*;

    localparam int LOG2N       = 4;
    localparam int N           = 1 << LOG2N;
    localparam int totalFrames = 7;
    localparam int doneTimeout = 4 * LOG2N * N + 64;    // far above compute plus unload

    logic        clk, rst, loadValid, start, inverse;
    logic        busy, outValid, done, timedOut;
    sample_t     loadReal, loadImag, outReal, outImag;
    int          valueErrors, protocolErrors, framesChecked, tbErrors;
    logic [31:0] lcgState;

    fftAccel #(.LOG2N(LOG2N)) UUT (
        .clk(clk), .rst(rst), .loadValid(loadValid), .loadReal(loadReal),
        .loadImag(loadImag), .start(start), .inverse(inverse), .busy(busy),
        .outValid(outValid), .outReal(outReal), .outImag(outImag), .done(done));

    fftChecker #(.LOG2N(LOG2N)) iChecker (
        .clk(clk), .rst(rst), .loadValid(loadValid), .loadReal(loadReal),
        .loadImag(loadImag), .start(start), .inverse(inverse), .busy(busy),
        .outValid(outValid), .outReal(outReal), .outImag(outImag), .done(done),
        .valueErrors(valueErrors), .protocolErrors(protocolErrors),
        .framesChecked(framesChecked));

    always #20 clk = ~clk;                              // 40 ns period

    // lcg, samples limited to +/-4095
    function automatic sample_t nextRandom();
        int span;
        lcgState   = lcgState * 32'd1664525 + 32'd1013904223;
        span       = int'(lcgState[31:16]) % 8191;
        nextRandom = sample_t'(span - 4095);
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;                                             // drive just after the edge
    endtask

    task automatic loadFrame(input logic impulse);
        for (int i = 0; i < N; i++) begin
            nextCycle();
            loadValid = 1'b1;
            if (impulse) begin
                loadReal = (i == 0) ? 16'sd1600 : 16'sd0;
                loadImag = '0;
            end else begin
                loadReal = nextRandom();
                loadImag = nextRandom();
            end
        end
        nextCycle();
        loadValid = 1'b0;
    endtask

    task automatic waitDone();
        int cycles;
        cycles = 0;
        while (!timedOut && done !== 1'b1) begin
            nextCycle();
            cycles++;
            if (cycles > doneTimeout) begin
                $display("timeout: done did not arrive within %0d cycles", doneTimeout);
                timedOut = 1'b1;
                tbErrors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // one frame, optionally with requests while busy
    //////////////////////////////////////////////////

    task automatic runFrame(input logic impulse, input logic inv, input logic poke);
        if (!timedOut) begin
            loadFrame(impulse);
            start   = 1'b1;
            inverse = inv;
            nextCycle();
            start   = 1'b0;
            inverse = 1'b0;
            if (poke) begin
                start     = 1'b1;                       // busy since the start edge
                loadValid = 1'b1;
                loadReal  = 16'sh1234;
                loadImag  = -16'sh0567;
                repeat (2) nextCycle();
                start     = 1'b0;
                loadValid = 1'b0;
            end
            waitDone();
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        loadValid = 1'b0;
        loadReal  = '0;
        loadImag  = '0;
        start     = 1'b0;
        inverse   = 1'b0;
        tbErrors  = 0;
        timedOut  = 1'b0;
        lcgState  = 32'hb7f1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (10) nextCycle();                        // idle, no start
        runFrame(1'b1, 1'b0, 1'b0);                     // impulse
        repeat (3) runFrame(1'b0, 1'b0, 1'b0);
        runFrame(1'b0, 1'b1, 1'b0);                     // ifft
        runFrame(1'b0, 1'b0, 1'b1);
        runFrame(1'b0, 1'b0, 1'b0);                     // frame after the ignored requests
        repeat (4) nextCycle();
        if (!timedOut && framesChecked != totalFrames) begin
            $display("only %0d of %0d frames were checked", framesChecked, totalFrames);
            tbErrors++;
        end
        $display("errors: %0d value, %0d protocol, %0d testbench",
                 valueErrors, protocolErrors, tbErrors);
        if (valueErrors + protocolErrors + tbErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verif/fftChecker.sv */
`timescale 1ns/1ps

module fftChecker #(
    parameter int LOG2N = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            loadValid,
    input  fftPkg::sample_t loadReal,
    input  fftPkg::sample_t loadImag,
    input  logic            start,
    input  logic            inverse,
    input  logic            busy,
    input  logic            outValid,
    input  fftPkg::sample_t outReal,
    input  fftPkg::sample_t outImag,
    input  logic            done,
    output int              valueErrors,
    output int              protocolErrors,
    output int              framesChecked
);

    import fftPkg::*;

    localparam int  N  = 1 << LOG2N;
    localparam real pi = 3.14159265358979;

    typedef logic [N-1:0][2*sampleWidth-1:0] frame_t;  // {real, imag} per sample

    frame_t  loaded, expected;
    int      loadCount, outCount;
    logic    active, lastOutValid, busyModel;
    logic    impulseFrame;
    sample_t impulseBin;

    function automatic longint roundToInt(input real v);
        if (v >= 0.0) begin
            roundToInt = $rtoi(v + 0.5);
        end else begin
            roundToInt = -$rtoi(0.5 - v);               // halves round away from zero
        end
    endfunction

    // only sample 0 carries a value, and it is real
    function automatic logic isImpulse(input frame_t samples);
        logic single;
        single = (samples[0][2*sampleWidth-1:sampleWidth] != '0) &&
                 (samples[0][sampleWidth-1:0] == '0);
        for (int i = 1; i < N; i++) begin
            if (samples[i] != '0) begin
                single = 1'b0;
            end
        end
        return single;
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // bit-reversed load then radix-2 dit stages that each halve
    function automatic frame_t fftReference(input frame_t samples, input logic inv);
        sample_t memReal [N];
        sample_t memImag [N];
        frame_t  result;
        int      rev, low, a, b, k;
        longint  wCos, wSin, aRe, aIm, bRe, bIm, bwRe, bwIm;
        for (int i = 0; i < N; i++) begin
            rev = 0;
            for (int n = 0; n < LOG2N; n++) begin
                rev = rev | (((i >> n) & 1) << (LOG2N - 1 - n));
            end
            memReal[rev] = samples[i][2*sampleWidth-1:sampleWidth];
            memImag[rev] = samples[i][sampleWidth-1:0];
        end
        for (int s = 0; s < LOG2N; s++) begin
            for (int j = 0; j < N / 2; j++) begin
                low  = j % (1 << s);                    // position inside the group
                a    = ((j - low) << 1) + low;
                b    = a + (1 << s);
                k    = low * 32 / (2 << s);             // angle on the 32-point circle
                wCos = roundToInt(16384.0 * $cos(2.0 * pi * k / 32.0));
                wSin = roundToInt(16384.0 * $sin(2.0 * pi * k / 32.0));
                if (!inv) begin
                    wSin = -wSin;                       // forward uses exp(-j..)
                end
                aRe  = memReal[a];
                aIm  = memImag[a];
                bRe  = memReal[b];
                bIm  = memImag[b];
                bwRe = (bRe * wCos - bIm * wSin) >>> 14;
                bwIm = (bRe * wSin + bIm * wCos) >>> 14;
                memReal[a] = sample_t'((aRe + bwRe) >>> 1);
                memImag[a] = sample_t'((aIm + bwIm) >>> 1);
                memReal[b] = sample_t'((aRe - bwRe) >>> 1);
                memImag[b] = sample_t'((aIm - bwIm) >>> 1);
            end
        end
        for (int i = 0; i < N; i++) begin
            result[i] = {memReal[i], memImag[i]};
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // frame tracking and comparison
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        sample_t expReal, expImag;
        if (rst) begin
            loadCount      = 0;
            outCount       = N;                         // no stream expected yet
            active         = 1'b0;
            lastOutValid   = 1'b0;
            impulseFrame   = 1'b0;
            impulseBin     = '0;
            valueErrors    = 0;
            protocolErrors = 0;
            framesChecked  = 0;
        end else begin
            busyModel = active && !done;                // busy drops in the done cycle
            if (busy !== busyModel) begin
                $display("[FAIL] busy = %h, expected %h", busy, busyModel);
                valueErrors++;
            end
            if (loadValid && !busyModel) begin
                loaded[loadCount] = {loadReal, loadImag};
                loadCount = (loadCount + 1) % N;
            end
            if (outValid) begin
                if (outCount < N) begin
                    expReal = expected[outCount][2*sampleWidth-1:sampleWidth];
                    expImag = expected[outCount][sampleWidth-1:0];
                    if (outReal !== expReal) begin
                        $display("[FAIL] outReal bin %0d = %h, expected %h",
                                 outCount, outReal, expReal);
                        valueErrors++;
                    end
                    if (outImag !== expImag) begin
                        $display("[FAIL] outImag bin %0d = %h, expected %h",
                                 outCount, outImag, expImag);
                        valueErrors++;
                    end
                    // an impulse spreads evenly over all bins
                    if (impulseFrame) begin
                        if (outReal !== impulseBin) begin
                            $display("[FAIL] outReal impulse bin %0d = %h, expected %h",
                                     outCount, outReal, impulseBin);
                            valueErrors++;
                        end
                        if (outImag !== 16'h0000) begin
                            $display("[FAIL] outImag impulse bin %0d = %h, expected %h",
                                     outCount, outImag, 16'h0000);
                            valueErrors++;
                        end
                    end
                end else begin
                    $display("an output appeared outside the stream of an accepted start");
                    protocolErrors++;
                end
                outCount++;
            end
            if (lastOutValid && !outValid && !done) begin
                $display("done did not follow the last output of a frame");
                protocolErrors++;
            end
            if (done) begin
                if (!active || outCount != N) begin
                    $display("done came after %0d outputs instead of %0d", outCount, N);
                    protocolErrors++;
                end else begin
                    framesChecked++;
                end
                active = 1'b0;
            end
            if (start && !busyModel) begin
                expected     = fftReference(loaded, inverse);
                impulseFrame = isImpulse(loaded);
                impulseBin   = sample_t'(int'(sample_t'(
                                   loaded[0][2*sampleWidth-1:sampleWidth])) / N);
                active       = 1'b1;
                outCount     = 0;
            end
            lastOutValid = outValid;
        end
    end

endmodule

/* verilog.f */
verilog/fftPkg.sv
verilog/fftCtrlPkg.sv
verilog/twiddleRom.sv
verilog/butterflyUnit.sv
verilog/addressGenerator.sv
verilog/fftRam.sv
verilog/fftControl.sv
verilog/fftAccel.sv
verif/fftChecker.sv
verif/fftAccelTb.sv

/* verilog/addressGenerator.sv */
`timescale 1ns/1ps

module addressGenerator #(
    parameter int LOG2N = 4
) (
    input  fftPkg::stage_t   stage,
    input  fftPkg::index_t   bfly,
    output fftPkg::index_t   indexA,
    output fftPkg::index_t   indexB,
    output fftPkg::twIndex_t twIndex
);

    import fftPkg::*;

    localparam index_t bflyMask  = index_t'((1 << (LOG2N - 1)) - 1);   // n/2 butterflies
    localparam index_t lastIndex = index_t'((1 << LOG2N) - 1);

    always_comb begin
        index_t lowMask;
        index_t lowBits;
        index_t highBits;

        lowMask  = index_t'((1 << stage) - 1);
        lowBits  = bfly & bflyMask & lowMask;               // position inside the group
        highBits = (bfly & bflyMask & ~lowMask) << 1;       // group number, opened at bit stage

        indexA = highBits | lowBits;
        indexB = indexA | (index_t'(1) << stage);           // partner is 2^stage away

        // (j mod 2^s) * 2^(4-s) on the 32-point circle
        twIndex = twIndex_t'(lowBits << (maxLog2N - 1 - stage));

        // pair must stay ordered and inside the frame for any count the FSM hands over
        assert (indexA < indexB && indexB <= lastIndex)
            else $error("addressGenerator: bad pair %0d/%0d at stage %0d", indexA, indexB, stage);
    end

endmodule

/* verilog/butterflyUnit.sv */
`timescale 1ns/1ps

module butterflyUnit (
    input  fftPkg::sample_t  aReal,
    input  fftPkg::sample_t  aImag,
    input  fftPkg::sample_t  bReal,
    input  fftPkg::sample_t  bImag,
    input  fftPkg::twiddle_t twCos,
    input  fftPkg::twiddle_t twSin,
    output fftPkg::sample_t  xReal,
    output fftPkg::sample_t  xImag,
    output fftPkg::sample_t  yReal,
    output fftPkg::sample_t  yImag
);

    import fftPkg::*;

    localparam int prodWidth = 2 * sampleWidth + 1;         // product plus one bit for the sum
    localparam int bwWidth   = prodWidth - twFracBits;      // after dropping the fraction
    localparam int sumWidth  = bwWidth + 1;                 // a +/- bw growth

    logic signed [prodWidth-1:0] prodReal;
    logic signed [prodWidth-1:0] prodImag;
    logic signed [bwWidth-1:0]   bwReal;
    logic signed [bwWidth-1:0]   bwImag;
    logic signed [sumWidth-1:0]  sumReal;
    logic signed [sumWidth-1:0]  sumImag;
    logic signed [sumWidth-1:0]  difReal;
    logic signed [sumWidth-1:0]  difImag;

    always_comb begin
        // b * w, with w = cos + j*sin
        prodReal = prodWidth'(bReal) * prodWidth'(twCos) - prodWidth'(bImag) * prodWidth'(twSin);
        prodImag = prodWidth'(bReal) * prodWidth'(twSin) + prodWidth'(bImag) * prodWidth'(twCos);

        bwReal = prodReal[prodWidth-1:twFracBits];          // arithmetic >> 14
        bwImag = prodImag[prodWidth-1:twFracBits];

        sumReal = sumWidth'(aReal) + sumWidth'(bwReal);
        sumImag = sumWidth'(aImag) + sumWidth'(bwImag);
        difReal = sumWidth'(aReal) - sumWidth'(bwReal);
        difImag = sumWidth'(aImag) - sumWidth'(bwImag);
    end

    // halve and truncate, one bit of scaling per stage
    assign xReal = sumReal[sampleWidth:1];
    assign xImag = sumImag[sampleWidth:1];
    assign yReal = difReal[sampleWidth:1];
    assign yImag = difImag[sampleWidth:1];

endmodule

/* verilog/fftAccel.sv */
`timescale 1ns/1ps

module fftAccel #(
    parameter int LOG2N = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            loadValid,
    input  fftPkg::sample_t loadReal,
    input  fftPkg::sample_t loadImag,
    input  logic            start,
    input  logic            inverse,
    output logic            busy,
    output logic            outValid,
    output fftPkg::sample_t outReal,
    output fftPkg::sample_t outImag,
    output logic            done
);

    import fftPkg::*;

    localparam index_t lastIndex = index_t'((1 << LOG2N) - 1);

    stage_t   stage;
    index_t   bfly, indexA, indexB;
    twIndex_t twIndex;
    twiddle_t twCos, twSin;
    sample_t  rdRealA, rdImagA, rdRealB, rdImagB;
    sample_t  xReal, xImag, yReal, yImag;
    index_t   loadCount, loadIndex, unloadCount;
    logic     bfRead, bfWrite, unloading, unloadLast, invMode;
    logic     loadWrite;

    //////////////////////////////////////////////////
    // frame counters
    //////////////////////////////////////////////////

    assign loadWrite = loadValid & ~busy;               // loads only between frames

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            loadCount <= '0;
        end else if (loadWrite) begin
            loadCount <= (loadCount == lastIndex) ? '0 : loadCount + 1'b1;
        end
    end

    // bit-reversed slot so the stages run in natural order
    always_comb begin
        loadIndex = '0;
        for (int i = 0; i < LOG2N; i++) begin
            loadIndex[i] = loadCount[LOG2N-1-i];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            unloadCount <= '0;
        end else if (unloading) begin
            unloadCount <= (unloadCount == lastIndex) ? '0 : unloadCount + 1'b1;
        end
    end

    assign unloadLast = unloading & (unloadCount == lastIndex);

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    fftControl #(.LOG2N(LOG2N)) iControl (
        .clk(clk), .rst(rst), .start(start), .inverse(inverse), .unloadLast(unloadLast),
        .busy(busy), .stage(stage), .bfly(bfly), .bfRead(bfRead), .bfWrite(bfWrite),
        .unloading(unloading), .outValid(outValid), .done(done), .invMode(invMode));

    addressGenerator #(.LOG2N(LOG2N)) iAgen (
        .stage(stage), .bfly(bfly), .indexA(indexA), .indexB(indexB), .twIndex(twIndex));

    twiddleRom iRom (
        .clk(clk), .twIndex(twIndex), .invMode(invMode), .twCos(twCos), .twSin(twSin));

    butterflyUnit iBfly (
        .aReal(rdRealA), .aImag(rdImagA), .bReal(rdRealB), .bImag(rdImagB),
        .twCos(twCos), .twSin(twSin),
        .xReal(xReal), .xImag(xImag), .yReal(yReal), .yImag(yImag));

    fftRam #(.LOG2N(LOG2N)) iRam (
        .clk(clk), .rst(rst),
        .rdIndexA(bfRead ? indexA : unloadCount),       // unload address outside READ
        .rdIndexB(indexB),
        .wrEnA(loadWrite | bfWrite),
        .wrEnB(bfWrite),
        .wrIndexA(bfWrite ? indexA : loadIndex),
        .wrIndexB(indexB),
        .wrRealA(bfWrite ? xReal : loadReal),
        .wrImagA(bfWrite ? xImag : loadImag),
        .wrRealB(yReal), .wrImagB(yImag),
        .rdRealA(rdRealA), .rdImagA(rdImagA), .rdRealB(rdRealB), .rdImagB(rdImagB));

    // port A read register holds each bin on its outValid cycle
    assign outReal = rdRealA;
    assign outImag = rdImagA;

endmodule

/* verilog/fftControl.sv */
`timescale 1ns/1ps

module fftControl #(
    parameter int LOG2N = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           inverse,
    input  logic           unloadLast,
    output logic           busy,
    output fftPkg::stage_t stage,
    output fftPkg::index_t bfly,
    output logic           bfRead,
    output logic           bfWrite,
    output logic           unloading,
    output logic           outValid,
    output logic           done,
    output logic           invMode
);

    import fftPkg::*;
    import fftCtrlPkg::*;

    localparam index_t lastBfly  = index_t'((1 << (LOG2N - 1)) - 1);
    localparam stage_t lastStage = stage_t'(LOG2N - 1);

    ctrlState_t state;

    //////////////////////////////////////////////////
    // state machine and butterfly counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            stage   <= '0;
            bfly    <= '0;
            invMode <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= READ;
                        stage   <= '0;
                        bfly    <= '0;
                        invMode <= inverse;             // held for the whole frame
                    end
                end
                READ: begin
                    state <= WRITE;
                end
                WRITE: begin
                    if (bfly == lastBfly) begin
                        bfly <= '0;
                        if (stage == lastStage) begin
                            state <= UNLOAD;            // all stages done
                        end else begin
                            stage <= stage + 1'b1;
                            state <= READ;
                        end
                    end else begin
                        bfly  <= bfly + 1'b1;
                        state <= READ;
                    end
                end
                UNLOAD: begin
                    if (unloadLast) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ram read data lags the unload address by one cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
            done     <= 1'b0;
        end else begin
            outValid <= (state == UNLOAD);
            done     <= (state == FINISH);              // lines up behind the last bin
        end
    end

    assign busy      = (state != IDLE);
    assign bfRead    = (state == READ);
    assign bfWrite   = (state == WRITE);
    assign unloading = (state == UNLOAD);

    //////////////////////////////////////////////////
    // sequencing checks
    //////////////////////////////////////////////////

    doneAfterStream: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(outValid) && !outValid)
        else $error("fftControl: done not right after the output stream");

    doneOneCycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("fftControl: done longer than one cycle");

    writeAfterRead: assert property (@(posedge clk) disable iff (rst)
        bfWrite |-> $past(bfRead))
        else $error("fftControl: butterfly write without a read before it");

endmodule

/* verilog/fftCtrlPkg.sv */
package fftCtrlPkg;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////

    // READ and WRITE alternate once per butterfly,
    // UNLOAD streams the frame out, FINISH raises done
    typedef enum logic [2:0] {
        IDLE,                                           // loading allowed, waits for start
        READ,                                           // ram and rom fetch a butterfly
        WRITE,                                          // butterfly results go back
        UNLOAD,                                         // one bin read per cycle
        FINISH                                          // last cycle of a frame
    } ctrlState_t;

endpackage

/* verilog/fftPkg.sv */
package fftPkg;

    //////////////////////////////////////////////////
    // datapath widths
    //////////////////////////////////////////////////

    localparam int sampleWidth = 16;                    // real or imaginary part
    localparam int twFracBits  = 14;                    // q1.14 coefficients
    localparam int maxLog2N    = 5;                     // 32 points at most

    //////////////////////////////////////////////////
    // datapath types
    //////////////////////////////////////////////////

    // one signed component of a complex sample
    typedef logic signed [sampleWidth-1:0] sample_t;

    // cos or sin coefficient, one sign bit, one integer bit, fraction
    typedef logic signed [twFracBits+1:0] twiddle_t;

    typedef logic [maxLog2N-1:0] index_t;               // ram slot or sample number
    typedef logic [2:0] stage_t;                        // 0 .. maxLog2N-1

    // only the first half of the 32-entry circle is ever addressed
    typedef logic [maxLog2N-2:0] twIndex_t;

endpackage

/* verilog/fftRam.sv */
`timescale 1ns/1ps

module fftRam #(
    parameter int LOG2N = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  fftPkg::index_t  rdIndexA,
    input  fftPkg::index_t  rdIndexB,
    input  logic            wrEnA,
    input  logic            wrEnB,
    input  fftPkg::index_t  wrIndexA,
    input  fftPkg::index_t  wrIndexB,
    input  fftPkg::sample_t wrRealA,
    input  fftPkg::sample_t wrImagA,
    input  fftPkg::sample_t wrRealB,
    input  fftPkg::sample_t wrImagB,
    output fftPkg::sample_t rdRealA,
    output fftPkg::sample_t rdImagA,
    output fftPkg::sample_t rdRealB,
    output fftPkg::sample_t rdImagB
);

    import fftPkg::*;

    localparam int     N         = 1 << LOG2N;
    localparam index_t lastIndex = index_t'(N - 1);

    sample_t realMem [N];
    sample_t imagMem [N];

    always_ff @(posedge clk) begin
        if (wrEnA) begin                                    // load or butterfly top output
            realMem[wrIndexA[LOG2N-1:0]] <= wrRealA;
            imagMem[wrIndexA[LOG2N-1:0]] <= wrImagA;
        end
        if (wrEnB) begin                                    // butterfly bottom output
            realMem[wrIndexB[LOG2N-1:0]] <= wrRealB;
            imagMem[wrIndexB[LOG2N-1:0]] <= wrImagB;
        end
    end

    // reads see the old word on a same-cycle write
    always_ff @(posedge clk) begin
        rdRealA <= realMem[rdIndexA[LOG2N-1:0]];
        rdImagA <= imagMem[rdIndexA[LOG2N-1:0]];
        rdRealB <= realMem[rdIndexB[LOG2N-1:0]];
        rdImagB <= imagMem[rdIndexB[LOG2N-1:0]];
    end

    //////////////////////////////////////////////////
    // write port checks
    //////////////////////////////////////////////////

    writeCollision: assert property (@(posedge clk) disable iff (rst)
        !(wrEnA && wrEnB && wrIndexA == wrIndexB))
        else $error("fftRam: both write ports hit index %0d", wrIndexA);

    writeRange: assert property (@(posedge clk) disable iff (rst)
        (!wrEnA || wrIndexA <= lastIndex) && (!wrEnB || wrIndexB <= lastIndex))
        else $error("fftRam: write outside the %0d-entry frame", N);

endmodule

/* verilog/twiddleRom.sv */
`timescale 1ns/1ps

module twiddleRom (
    input  logic             clk,
    input  fftPkg::twIndex_t twIndex,
    input  logic             invMode,
    output fftPkg::twiddle_t twCos,
    output fftPkg::twiddle_t twSin
);

    import fftPkg::*;

    twiddle_t cosVal;
    twiddle_t sinVal;

    // quarter wave, 16384 * cos(2*pi*k/32) for k = 0 .. 8
    function automatic twiddle_t quarterWave(input twIndex_t k);
        case (k)
            4'd0:    quarterWave = 16'sd16384;
            4'd1:    quarterWave = 16'sd16069;
            4'd2:    quarterWave = 16'sd15137;
            4'd3:    quarterWave = 16'sd13623;
            4'd4:    quarterWave = 16'sd11585;
            4'd5:    quarterWave = 16'sd9102;
            4'd6:    quarterWave = 16'sd6270;
            4'd7:    quarterWave = 16'sd3196;
            default: quarterWave = 16'sd0;                  // k = 8, a quarter turn
        endcase
    endfunction

    // fold the half circle onto the quarter table
    always_comb begin
        if (twIndex <= 4'd8) begin
            cosVal = quarterWave(twIndex);
            sinVal = quarterWave(4'd8 - twIndex);
        end else begin
            cosVal = -quarterWave(4'd0 - twIndex);          // 16 - k, wraps in 4 bits
            sinVal = quarterWave(twIndex - 4'd8);
        end
    end

    // forward transform uses exp(-j..), so the sine goes out negated
    always_ff @(posedge clk) begin
        twCos <= cosVal;
        twSin <= invMode ? sinVal : -sinVal;
    end

endmodule
